// File: design/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// instructions per output bundle
`define FETCH_WIDTH 4

// blocks looked up ahead of the fetch pointer
`define PREFETCH_DISTANCE 3

// one prediction per word of the prefetch window
`define PRED_SLOTS (2 * `PREFETCH_DISTANCE)

// tags run 1 to 15, tag 0 means none
`define NUM_MEM_TAGS 15

`define ICACHE_LINES 32
`define BTB_ENTRIES 16

// history width, also the counter table index width
`define BHR_DEPTH 4

`define IBUFF_DEPTH 8
`define IBUFF_CNT_W ($clog2(`IBUFF_DEPTH + 1))
`define FETCH_CNT_W ($clog2(`FETCH_WIDTH + 1))

`endif

// File: design/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    // memory block of two words
    // word 0 sits at the lower address
    typedef logic [1:0][31:0] block_t;

    // memory transaction tag, 0 means none
    typedef logic [3:0] mem_tag_t;

    // branch resolution task from the back end
    typedef enum logic [1:0] {
        br_none,
        br_clear,
        br_squash
    } br_task_t;

    // global branch history
    typedef logic [`BHR_DEPTH-1:0] bhr_t;

    // one entry of the bundle sent to the instruction buffer
    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        addr_t       pc;
        addr_t       npc;
        logic        pred_taken;
        bhr_t        bhr;
    } inst_packet_t;

endpackage

// File: design/icache.sv
`include "fetch_settings.svh"

module icache (
    input  logic                                        clock,
    input  logic                                        reset,
    input  fetch_pkg::addr_t  [`PREFETCH_DISTANCE-1:0]  rd_addr,
    input  logic                                        write_en,
    input  fetch_pkg::addr_t                            write_addr,
    input  fetch_pkg::block_t                           write_data,
    output fetch_pkg::block_t [`PREFETCH_DISTANCE-1:0]  rd_data,
    output logic              [`PREFETCH_DISTANCE-1:0]  rd_valid
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(`ICACHE_LINES);
    // 3 offset bits below the index
    localparam int TAG_W = 32 - 3 - IDX_W;

    block_t                   data_mem [`ICACHE_LINES];
    logic [TAG_W-1:0]         tag_mem  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] line_valid;

    logic [IDX_W-1:0] rd_idx [`PREFETCH_DISTANCE];
    logic [TAG_W-1:0] rd_tag [`PREFETCH_DISTANCE];
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    assign wr_idx = write_addr[3 +: IDX_W];
    assign wr_tag = write_addr[31 -: TAG_W];

    // parallel read ports, one per prefetch slot
    always_comb begin
        for (int i = 0; i < `PREFETCH_DISTANCE; i++) begin
            rd_idx[i] = rd_addr[i][3 +: IDX_W];
            rd_tag[i] = rd_addr[i][31 -: TAG_W];
            rd_data[i] = data_mem[rd_idx[i]];
            // hit needs a valid line with matching tag
            rd_valid[i] = line_valid[rd_idx[i]] && (tag_mem[rd_idx[i]] == rd_tag[i]);
        end
    end

    // valid bits, cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (write_en) begin
            line_valid[wr_idx] <= 1'b1;
        end
    end

    // block data and tags
    // a fill simply replaces whatever the line held
    always_ff @(posedge clock) begin
        if (write_en) begin
            data_mem[wr_idx] <= write_data;
            tag_mem[wr_idx]  <= wr_tag;
        end
    end

endmodule

// File: design/miss_tracker.sv
`include "fetch_settings.svh"

module miss_tracker (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        grant,
    input  fetch_pkg::addr_t [`PREFETCH_DISTANCE-1:0]   lookup_addr,
    input  logic             [`PREFETCH_DISTANCE-1:0]   lookup_needed,
    input  fetch_pkg::mem_tag_t                         mem_tag,
    input  fetch_pkg::mem_tag_t                         mem_data_tag,
    input  fetch_pkg::block_t                           mem_data,
    output logic                                        mem_en,
    output fetch_pkg::addr_t                            mem_addr,
    output logic                                        fill_en,
    output fetch_pkg::addr_t                            fill_addr,
    output fetch_pkg::block_t                           fill_data
);
    import fetch_pkg::*;

    // block address per outstanding tag, tag 0 is never used
    addr_t [`NUM_MEM_TAGS:1]        pend_addr;
    logic  [`NUM_MEM_TAGS:1]        pend_valid;
    logic  [`PREFETCH_DISTANCE-1:0] outstanding;
    logic                           record;

    // returning tag we know about becomes a cache fill
    assign fill_en   = (mem_data_tag != '0) && pend_valid[mem_data_tag];
    assign fill_addr = pend_addr[mem_data_tag];
    assign fill_data = mem_data;

    // block already in flight under some tag
    always_comb begin
        for (int i = 0; i < `PREFETCH_DISTANCE; i++) begin
            outstanding[i] = 1'b0;
            for (int t = 1; t <= `NUM_MEM_TAGS; t++) begin
                if (pend_valid[t] && (pend_addr[t][31:3] == lookup_addr[i][31:3])) begin
                    outstanding[i] = 1'b1;
                end
            end
        end
    end

    // lowest slot wins, hence the downward walk
    always_comb begin
        mem_en   = 1'b0;
        mem_addr = '0;
        if (grant) begin
            for (int i = `PREFETCH_DISTANCE - 1; i >= 0; i--) begin
                if (lookup_needed[i] && !outstanding[i]) begin
                    mem_en   = 1'b1;
                    mem_addr = {lookup_addr[i][31:3], 3'b000};
                end
            end
        end
    end

    // refused request (tag 0) leaves no entry and gets retried
    assign record = mem_en && (mem_tag != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            pend_valid <= '0;
        end else begin
            if (fill_en) begin
                pend_valid[mem_data_tag] <= 1'b0;
            end
            // new request after the free, in case memory reuses the tag
            if (record) begin
                pend_valid[mem_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (record) begin
            pend_addr[mem_tag] <= mem_addr;
        end
    end

endmodule

// File: design/branch_predictor.sv
`include "fetch_settings.svh"

module branch_predictor (
    input  logic                                    clock,
    input  logic                                    reset,
    input  fetch_pkg::addr_t                        rd_pc,
    input  fetch_pkg::bhr_t                         rd_bhr,
    input  logic                                    wr_en,
    input  logic                                    wr_taken,
    input  fetch_pkg::addr_t                        wr_pc,
    input  fetch_pkg::addr_t                        wr_target,
    input  fetch_pkg::bhr_t                         wr_bhr,
    output logic             [`PRED_SLOTS-1:0]      pred_taken,
    output fetch_pkg::addr_t [`PRED_SLOTS-1:0]      pred_target
);
    import fetch_pkg::*;

    localparam int BTB_IDX_W   = $clog2(`BTB_ENTRIES);
    localparam int BTB_TAG_W   = 32 - 2 - BTB_IDX_W;
    // counter table indexed by pc bits xor history
    localparam int PHT_ENTRIES = 1 << `BHR_DEPTH;

    logic [BTB_TAG_W-1:0]   btb_tag    [`BTB_ENTRIES];
    addr_t                  btb_target [`BTB_ENTRIES];
    logic [`BTB_ENTRIES-1:0] btb_valid;
    logic [1:0]             pht        [PHT_ENTRIES];

    addr_t                  slot_pc  [`PRED_SLOTS];
    logic [BTB_IDX_W-1:0]   slot_btb [`PRED_SLOTS];
    bhr_t                   slot_pht [`PRED_SLOTS];

    logic [BTB_IDX_W-1:0]   wr_btb;
    bhr_t                   wr_pht;

    // slot k looks at the k-th word after rd_pc
    always_comb begin
        for (int k = 0; k < `PRED_SLOTS; k++) begin
            slot_pc[k]  = rd_pc + addr_t'(4 * k);
            slot_btb[k] = slot_pc[k][2 +: BTB_IDX_W];
            slot_pht[k] = slot_pc[k][2 +: `BHR_DEPTH] ^ rd_bhr;
            // taken needs a btb hit and counter of 2 or 3
            pred_taken[k] = btb_valid[slot_btb[k]]
                && (btb_tag[slot_btb[k]] == slot_pc[k][31 -: BTB_TAG_W])
                && pht[slot_pht[k]][1];
            pred_target[k] = btb_target[slot_btb[k]];
        end
    end

    assign wr_btb = wr_pc[2 +: BTB_IDX_W];
    // history as seen when the branch was predicted
    assign wr_pht = wr_pc[2 +: `BHR_DEPTH] ^ wr_bhr;

    always_ff @(posedge clock) begin
        if (reset) begin
            btb_valid <= '0;
            // weakly not taken
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= 2'b01;
            end
        end else if (wr_en) begin
            btb_valid[wr_btb] <= 1'b1;
            // saturating two-bit update
            if (wr_taken && (pht[wr_pht] != 2'b11)) begin
                pht[wr_pht] <= pht[wr_pht] + 2'b01;
            end else if (!wr_taken && (pht[wr_pht] != 2'b00)) begin
                pht[wr_pht] <= pht[wr_pht] - 2'b01;
            end
        end
    end

    // target installed on every resolved branch
    always_ff @(posedge clock) begin
        if (wr_en) begin
            btb_tag[wr_btb]    <= wr_pc[31 -: BTB_TAG_W];
            btb_target[wr_btb] <= wr_target;
        end
    end

endmodule

// File: design/fetch.sv
`include "fetch_settings.svh"

module fetch (
    input  logic                                            clock,
    input  logic                                            reset,
    input  fetch_pkg::addr_t                                target,
    input  fetch_pkg::br_task_t                             br_task,
    input  logic [`IBUFF_CNT_W-1:0]                         ibuff_open,
    input  fetch_pkg::bhr_t                                 rd_bhr,
    input  fetch_pkg::block_t         [`PREFETCH_DISTANCE-1:0] hit_data,
    input  logic                      [`PREFETCH_DISTANCE-1:0] hit_valid,
    input  logic                      [`PRED_SLOTS-1:0]     pred_taken,
    input  fetch_pkg::addr_t          [`PRED_SLOTS-1:0]     pred_target,
    output fetch_pkg::addr_t          [`PREFETCH_DISTANCE-1:0] prefetch_addr,
    output logic                      [`PREFETCH_DISTANCE-1:0] prefetch_needed,
    output fetch_pkg::addr_t                                pred_pc,
    output fetch_pkg::inst_packet_t   [`FETCH_WIDTH-1:0]    out_insts,
    output logic [`FETCH_CNT_W-1:0]                         out_num_insts,
    output fetch_pkg::addr_t                                npc
);
    import fetch_pkg::*;

    localparam int CNT_W  = `FETCH_CNT_W;
    localparam int OPEN_W = `IBUFF_CNT_W;

    addr_t                              pointer;
    addr_t                              next_ptr;
    logic                               squash;
    logic [`PREFETCH_DISTANCE-1:0]      slot_used;
    logic                               jumped;

    // predictions re-indexed by word position from the aligned pointer
    logic  [`PRED_SLOTS-1:0]            taken_word;
    addr_t [`PRED_SLOTS-1:0]            target_word;

    // hit words re-indexed from the pointer word
    logic [`PRED_SLOTS-1:0]             word_hit;
    logic [`PRED_SLOTS-1:0]             rel_hit;
    logic [`PRED_SLOTS-1:0][31:0]       rel_inst;

    logic [OPEN_W-1:0]                  space;
    inst_packet_t [`FETCH_WIDTH-1:0]    next_insts;
    logic [CNT_W-1:0]                   next_num;
    logic                               live;

    assign squash  = (br_task == br_squash);
    // squash target is visible right away
    assign npc     = squash ? target : pointer;
    assign pred_pc = npc;

    // odd pointer shifts the window by one word
    assign taken_word  = npc[2] ? {pred_taken[`PRED_SLOTS-2:0], 1'b0} : pred_taken;
    assign target_word = npc[2] ? {pred_target[`PRED_SLOTS-2:0], addr_t'(0)} : pred_target;

    // prefetch slots, redirected after a predicted-taken block
    always_comb begin
        jumped = 1'b0;
        prefetch_addr[0] = {npc[31:3], 3'b000};
        slot_used[0] = 1'b1;
        for (int i = 1; i < `PREFETCH_DISTANCE; i++) begin
            // jumped covers blocks before i-1
            slot_used[i] = slot_used[i-1] && !jumped;
            if (taken_word[2*i-2]) begin
                prefetch_addr[i] = {target_word[2*i-2][31:3], 3'b000};
            end else if (taken_word[2*i-1]) begin
                prefetch_addr[i] = {target_word[2*i-1][31:3], 3'b000};
            end else begin
                prefetch_addr[i] = prefetch_addr[i-1] + addr_t'(8);
            end
            jumped = jumped || taken_word[2*i-2] || taken_word[2*i-1];
        end
    end

    // only used slots that missed go to the tracker
    assign prefetch_needed = slot_used & ~hit_valid;

    always_comb begin
        for (int j = 0; j < `PRED_SLOTS; j++) begin
            word_hit[j] = hit_valid[j/2];
        end
    end

    assign rel_hit  = npc[2] ? (word_hit >> 1) : word_hit;
    assign rel_inst = npc[2] ? (hit_data >> 32) : hit_data;

    // room left in the instruction buffer, floored at 0
    assign space = (ibuff_open > OPEN_W'(out_num_insts))
        ? ibuff_open - OPEN_W'(out_num_insts) : '0;

    // bundle assembly from leading hit words
    always_comb begin
        next_insts = '0;
        next_num   = '0;
        next_ptr   = npc;
        live       = 1'b1;
        for (int k = 0; k < `FETCH_WIDTH; k++) begin
            if (live && rel_hit[k] && (k < int'(space))) begin
                next_insts[k].valid      = 1'b1;
                next_insts[k].inst       = rel_inst[k];
                next_insts[k].pc         = npc + addr_t'(4 * k);
                next_insts[k].npc        = pred_taken[k] ? pred_target[k]
                                                         : npc + addr_t'(4 * k + 4);
                next_insts[k].pred_taken = pred_taken[k];
                next_insts[k].bhr        = rd_bhr;
                next_num = CNT_W'(k + 1);
                next_ptr = next_insts[k].npc;
                // a taken branch ends the bundle
                live = !pred_taken[k];
            end else begin
                live = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pointer       <= '0;
            out_insts     <= '0;
            out_num_insts <= '0;
        end else if (squash) begin
            pointer       <= target;
            out_insts     <= '0;
            out_num_insts <= '0;
        end else begin
            // next_ptr stays at npc when nothing was sent
            pointer       <= next_ptr;
            out_insts     <= next_insts;
            out_num_insts <= next_num;
        end
    end

endmodule

// File: design/fetch_top.sv
`include "fetch_settings.svh"

module fetch_top (
    input  logic                                        clock,
    input  logic                                        reset,
    input  fetch_pkg::addr_t                            target,
    input  fetch_pkg::br_task_t                         br_task,
    input  logic                                        grant,
    input  logic [`IBUFF_CNT_W-1:0]                     ibuff_open,
    input  fetch_pkg::bhr_t                             rd_bhr,
    input  fetch_pkg::mem_tag_t                         mem_tag,
    input  fetch_pkg::mem_tag_t                         mem_data_tag,
    input  fetch_pkg::block_t                           mem_data,
    input  logic                                        pred_wr_en,
    input  logic                                        pred_wr_taken,
    input  fetch_pkg::addr_t                            pred_wr_pc,
    input  fetch_pkg::addr_t                            pred_wr_target,
    input  fetch_pkg::bhr_t                             pred_wr_bhr,
    output logic                                        mem_en,
    output fetch_pkg::addr_t                            mem_addr,
    output fetch_pkg::inst_packet_t [`FETCH_WIDTH-1:0]  out_insts,
    output logic [`FETCH_CNT_W-1:0]                     out_num_insts,
    output fetch_pkg::addr_t                            npc
);
    import fetch_pkg::*;

    // prefetch window between fetch, cache and tracker
    addr_t  [`PREFETCH_DISTANCE-1:0] prefetch_addr;
    logic   [`PREFETCH_DISTANCE-1:0] prefetch_needed;
    block_t [`PREFETCH_DISTANCE-1:0] hit_data;
    logic   [`PREFETCH_DISTANCE-1:0] hit_valid;

    // fill path from tracker to cache
    logic   fill_en;
    addr_t  fill_addr;
    block_t fill_data;

    // predictor lookup
    addr_t                    pred_pc;
    logic  [`PRED_SLOTS-1:0]  pred_taken;
    addr_t [`PRED_SLOTS-1:0]  pred_target;

    fetch fetch_0 (
        .clock(clock), .reset(reset), .target(target), .br_task(br_task),
        .ibuff_open(ibuff_open), .rd_bhr(rd_bhr),
        .hit_data(hit_data), .hit_valid(hit_valid),
        .pred_taken(pred_taken), .pred_target(pred_target),
        .prefetch_addr(prefetch_addr), .prefetch_needed(prefetch_needed),
        .pred_pc(pred_pc), .out_insts(out_insts), .out_num_insts(out_num_insts), .npc(npc)
    );

    icache icache_0 (
        .clock(clock), .reset(reset), .rd_addr(prefetch_addr),
        .write_en(fill_en), .write_addr(fill_addr), .write_data(fill_data),
        .rd_data(hit_data), .rd_valid(hit_valid)
    );

    miss_tracker tracker_0 (
        .clock(clock), .reset(reset), .grant(grant),
        .lookup_addr(prefetch_addr), .lookup_needed(prefetch_needed),
        .mem_tag(mem_tag), .mem_data_tag(mem_data_tag), .mem_data(mem_data),
        .mem_en(mem_en), .mem_addr(mem_addr),
        .fill_en(fill_en), .fill_addr(fill_addr), .fill_data(fill_data)
    );

    branch_predictor predictor_0 (
        .clock(clock), .reset(reset), .rd_pc(pred_pc), .rd_bhr(rd_bhr),
        .wr_en(pred_wr_en), .wr_taken(pred_wr_taken), .wr_pc(pred_wr_pc),
        .wr_target(pred_wr_target), .wr_bhr(pred_wr_bhr),
        .pred_taken(pred_taken), .pred_target(pred_target)
    );

endmodule

// File: testbench/fetch_tb.sv
`include "fetch_settings.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 1ns;

    import fetch_pkg::*;

    localparam int MAX_RECORDS = 64;

    logic                               clock;
    logic                               reset;
    addr_t                              target;
    br_task_t                           br_task;
    logic                               grant;
    logic [`IBUFF_CNT_W-1:0]            ibuff_open;
    bhr_t                               rd_bhr;
    mem_tag_t                           mem_tag;
    mem_tag_t                           mem_data_tag;
    block_t                             mem_data;
    logic                               pred_wr_en;
    logic                               pred_wr_taken;
    addr_t                              pred_wr_pc;
    addr_t                              pred_wr_target;
    bhr_t                               pred_wr_bhr;
    logic                               mem_en;
    addr_t                              mem_addr;
    inst_packet_t [`FETCH_WIDTH-1:0]    out_insts;
    logic [`FETCH_CNT_W-1:0]            out_num_insts;
    addr_t                              npc;

    // four words per record
    logic [31:0] records [4*MAX_RECORDS];

    // memory model with one entry per tag
    logic [`NUM_MEM_TAGS:1] tag_busy;
    addr_t                  tag_addr [`NUM_MEM_TAGS+1];
    int                     tag_due  [`NUM_MEM_TAGS+1];

    // inputs for the next cycle
    br_task_t                next_task;
    addr_t                   next_target;
    logic                    next_grant;
    logic [`IBUFF_CNT_W-1:0] next_open;
    logic                    next_wr_en;
    logic                    next_wr_taken;
    addr_t                   next_wr_pc;
    addr_t                   next_wr_target;

    // output tracking
    addr_t chain_pc;
    logic  prev_valid;
    logic [`IBUFF_CNT_W-1:0] prev_open;
    int    prev_num;
    logic  squash_prev;
    logic  trained;
    logic  timed_out;

    int cycle_count;
    int mismatches;
    int other_errors;

    fetch_top UUT (
        .clock(clock), .reset(reset), .target(target), .br_task(br_task),
        .grant(grant), .ibuff_open(ibuff_open), .rd_bhr(rd_bhr),
        .mem_tag(mem_tag), .mem_data_tag(mem_data_tag), .mem_data(mem_data),
        .pred_wr_en(pred_wr_en), .pred_wr_taken(pred_wr_taken), .pred_wr_pc(pred_wr_pc),
        .pred_wr_target(pred_wr_target), .pred_wr_bhr(pred_wr_bhr),
        .mem_en(mem_en), .mem_addr(mem_addr),
        .out_insts(out_insts), .out_num_insts(out_num_insts), .npc(npc)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // word stored at a byte address
    function automatic logic [31:0] mem_word(input addr_t addr);
        return {16'hA5A5 ^ addr[31:16], addr[15:0]};
    endfunction

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        mismatches++;
        $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic complain(input string what);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic finish_run;
        $display("cycles %0d, mismatches %0d, other errors %0d",
            cycle_count, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    // lowest due tag returns first and only one per cycle
    task automatic memory_return(output int ret);
        ret = 0;
        for (int t = `NUM_MEM_TAGS; t >= 1; t--) begin
            if (tag_busy[t] && tag_due[t] <= cycle_count) begin
                ret = t;
            end
        end
        mem_data_tag = mem_tag_t'(ret);
        mem_data = '0;
        if (ret != 0) begin
            mem_data[0] = mem_word(tag_addr[ret]);
            mem_data[1] = mem_word(tag_addr[ret] + 32'd4);
        end
    endtask

    // answer this cycle's request with a tag or 0
    task automatic memory_request;
        int free_tag;
        free_tag = 0;
        mem_tag = '0;
        if (!grant && mem_en) begin
            complain("memory request issued without grant");
        end
        if (mem_en) begin
            if (mem_addr[2:0] != 3'b000) begin
                mismatch("mem_addr[2:0]", 32'(mem_addr[2:0]), 32'd0);
            end
            for (int t = 1; t <= `NUM_MEM_TAGS; t++) begin
                if (tag_busy[t] && tag_addr[t] == mem_addr) begin
                    complain($sformatf("request for block %h that is still outstanding",
                        mem_addr));
                end
            end
            for (int t = `NUM_MEM_TAGS; t >= 1; t--) begin
                if (!tag_busy[t]) begin
                    free_tag = t;
                end
            end
            // refused one time in four, or when all tags are out
            if (($urandom % 4) != 0 && free_tag != 0) begin
                mem_tag = mem_tag_t'(free_tag);
                tag_busy[free_tag] = 1'b1;
                tag_addr[free_tag] = mem_addr;
                tag_due[free_tag] = cycle_count + 2 + int'($urandom % 5);
            end
        end
    endtask

    // registered outputs are stable since the edge
    task automatic check_outputs;
        int           limit;
        int           num;
        inst_packet_t pkt;
        num = int'(out_num_insts);
        limit = int'(prev_open) - prev_num;
        if (limit < 0) begin
            limit = 0;
        end
        if (prev_valid && num > limit) begin
            mismatch("out_num_insts over buffer limit", 32'(num), 32'(limit));
        end
        if (squash_prev && num != 0) begin
            mismatch("out_num_insts after squash", 32'(num), 32'd0);
        end
        for (int k = 0; k < `FETCH_WIDTH; k++) begin
            pkt = out_insts[k];
            if (pkt.valid != (k < num)) begin
                mismatch($sformatf("out_insts[%0d].valid", k), 32'(pkt.valid), 32'(k < num));
            end
            if (k < num) begin
                if (pkt.inst != mem_word(pkt.pc)) begin
                    mismatch($sformatf("out_insts[%0d].inst", k), pkt.inst, mem_word(pkt.pc));
                end
                // each pc follows the npc before it
                if (pkt.pc != chain_pc) begin
                    mismatch($sformatf("out_insts[%0d].pc", k), pkt.pc, chain_pc);
                end
                if (!pkt.pred_taken && pkt.npc != pkt.pc + 32'd4) begin
                    mismatch($sformatf("out_insts[%0d].npc", k), pkt.npc, pkt.pc + 32'd4);
                end
                if (!trained && pkt.pred_taken) begin
                    mismatch($sformatf("out_insts[%0d].pred_taken", k), 32'd1, 32'd0);
                end
                if (pkt.bhr != rd_bhr) begin
                    mismatch($sformatf("out_insts[%0d].bhr", k), 32'(pkt.bhr), 32'(rd_bhr));
                end
                chain_pc = pkt.npc;
            end
        end
        prev_open = ibuff_open;
        prev_num = num;
        prev_valid = 1'b1;
        squash_prev = (br_task == br_squash);
        if (squash_prev) begin
            // redirect is visible combinationally
            if (npc != target) begin
                mismatch("npc", npc, target);
            end
            chain_pc = target;
        end
    endtask

    // one clock cycle of driving, memory answers and checks
    task automatic tick;
        int ret_tag;
        @(posedge clock);
        cycle_count++;
        #10;
        br_task = next_task;
        target = next_target;
        grant = next_grant;
        ibuff_open = next_open;
        pred_wr_en = next_wr_en;
        pred_wr_taken = next_wr_taken;
        pred_wr_pc = next_wr_pc;
        pred_wr_target = next_wr_target;
        // one-shot requests
        next_task = br_none;
        next_wr_en = 1'b0;
        memory_return(ret_tag);
        #10;
        memory_request();
        // returned tag is free from the next cycle on
        if (ret_tag != 0) begin
            tag_busy[ret_tag] = 1'b0;
        end
        check_outputs();
    endtask

    task automatic wait_bundle(input int limit, input string what);
        int waited;
        waited = 0;
        while (out_num_insts == '0 && !timed_out) begin
            if (waited >= limit) begin
                complain($sformatf("timed out waiting for %s", what));
                timed_out = 1'b1;
            end else begin
                tick();
                waited++;
            end
        end
    endtask

    task automatic do_squash(input addr_t tgt, input addr_t first_pc, input int limit);
        next_task = br_squash;
        next_target = tgt;
        tick();
        tick();
        wait_bundle(limit, "instructions after a squash");
        if (!timed_out && out_insts[0].pc != first_pc) begin
            mismatch("out_insts[0].pc after squash", out_insts[0].pc, first_pc);
        end
    endtask

    task automatic expect_branch(input addr_t pc, input addr_t tgt, input int limit);
        int waited;
        int slot;
        waited = 0;
        slot = -1;
        while (slot < 0 && !timed_out) begin
            tick();
            for (int k = 0; k < int'(out_num_insts); k++) begin
                if (out_insts[k].pc == pc) begin
                    slot = k;
                end
            end
            if (slot < 0) begin
                if (waited >= limit) begin
                    complain($sformatf("trained branch at %h never fetched", pc));
                    timed_out = 1'b1;
                end
                waited++;
            end
        end
        if (!timed_out) begin
            // the taken branch ends its bundle
            if (slot != int'(out_num_insts) - 1) begin
                mismatch("taken branch slot", 32'(slot), 32'(int'(out_num_insts) - 1));
            end
            if (!out_insts[slot].pred_taken) begin
                mismatch("pred_taken of trained branch", 32'd0, 32'd1);
            end
            if (out_insts[slot].npc != tgt) begin
                mismatch("npc of trained branch", out_insts[slot].npc, tgt);
            end
            tick();
            wait_bundle(limit, "the bundle at a branch target");
            if (!timed_out && out_insts[0].pc != tgt) begin
                mismatch("out_insts[0].pc after taken branch", out_insts[0].pc, tgt);
            end
        end
    endtask

    initial begin
        int          rec;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        void'($urandom(90070));
        reset = 1'b1;
        target = '0;
        br_task = br_none;
        grant = 1'b0;
        ibuff_open = `IBUFF_CNT_W'(`IBUFF_DEPTH);
        rd_bhr = '0;
        mem_tag = '0;
        mem_data_tag = '0;
        mem_data = '0;
        pred_wr_en = 1'b0;
        pred_wr_taken = 1'b0;
        pred_wr_pc = '0;
        pred_wr_target = '0;
        pred_wr_bhr = '0;
        next_task = br_none;
        next_target = '0;
        next_grant = 1'b1;
        next_open = `IBUFF_CNT_W'(`IBUFF_DEPTH);
        next_wr_en = 1'b0;
        next_wr_taken = 1'b0;
        next_wr_pc = '0;
        next_wr_target = '0;
        tag_busy = '0;
        // pointer starts at 0 after reset
        chain_pc = '0;
        prev_valid = 1'b0;
        prev_open = '0;
        prev_num = 0;
        squash_prev = 1'b0;
        trained = 1'b0;
        timed_out = 1'b0;
        cycle_count = 0;
        mismatches = 0;
        other_errors = 0;
        $readmemh("testbench/fetch_input.txt", records);

        repeat (2) @(posedge clock);
        #10;
        reset = 1'b0;
        grant = next_grant;
        #10;
        if (out_num_insts != '0) begin
            mismatch("out_num_insts after reset", 32'(out_num_insts), 32'd0);
        end
        for (int k = 0; k < `FETCH_WIDTH; k++) begin
            if (out_insts[k].valid) begin
                mismatch($sformatf("out_insts[%0d].valid after reset", k), 32'd1, 32'd0);
            end
        end
        // empty cache and tracker, so block 0 goes out first once grant rises
        if (mem_en != 1'b1) begin
            mismatch("mem_en after reset", 32'(mem_en), 32'd1);
        end
        if (mem_addr != 32'd0) begin
            mismatch("mem_addr after reset", mem_addr, 32'd0);
        end

        rec = 0;
        op = records[0];
        while (op != 32'd0 && rec < MAX_RECORDS && !timed_out) begin
            a = records[4*rec+1];
            b = records[4*rec+2];
            c = records[4*rec+3];
            case (op)
                32'd1: do_squash(a, b, int'(c));
                32'd2: begin
                    next_wr_en = 1'b1;
                    next_wr_pc = a;
                    next_wr_target = b;
                    next_wr_taken = c[0];
                    trained = 1'b1;
                    tick();
                end
                32'd3: next_open = a[`IBUFF_CNT_W-1:0];
                32'd4: repeat (int'(a)) tick();
                32'd5: expect_branch(a, b, int'(c));
                32'd6: next_grant = a[0];
                default: complain($sformatf("unknown record type %0d", op));
            endcase
            rec++;
            op = records[4*rec];
        end
        finish_run();
    end

endmodule

// File: build.f
+incdir+design
design/fetch_pkg.sv
design/icache.sv
design/miss_tracker.sv
design/branch_predictor.sv
design/fetch.sv
design/fetch_top.sv
testbench/fetch_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module fetch_tb -f build.f -o fetch_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/fetch_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the testbench prints its verdict on a line of its own
if printf '%s\n' "$sim_out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// File: testbench/fetch_input.txt
// columns: op, value a, value b, value c, all hex
// op 1 squash(target, first pc, timeout) 2 update(pc, target, taken) 3 ibuff_open 4 run cycles 5 taken branch(pc, target, timeout) 6 grant 0 end
3 00000008 00000000 00000000
4 00000030 00000000 00000000
3 00000003 00000000 00000000
4 00000018 00000000 00000000
3 00000000 00000000 00000000
4 00000006 00000000 00000000
3 00000008 00000000 00000000
6 00000000 00000000 00000000
4 0000000a 00000000 00000000
6 00000001 00000000 00000000
1 00000200 00000200 00000040
4 00000014 00000000 00000000
2 00000114 00000400 00000001
2 00000114 00000400 00000001
1 00000100 00000100 00000040
5 00000114 00000400 00000040
4 00000014 00000000 00000000
1 00000344 00000344 00000040
3 00000005 00000000 00000000
4 00000020 00000000 00000000
3 00000008 00000000 00000000
1 000000f8 000000f8 00000040
5 00000114 00000400 00000040
4 00000010 00000000 00000000
0 00000000 00000000 00000000
